//--- build.f
source/epu_axi_pkg.sv
source/epu_cfg_pkg.sv
source/epu_buffer.sv
source/epu_mac_pipe.sv
source/epu_axi_slave.sv
source/epu_top.sv
verification/epu_properties.sv
verification/epu_tb.sv

//--- Bender.yml
package:
  name: epu

sources:
  - source/epu_axi_pkg.sv
  - source/epu_cfg_pkg.sv
  - source/epu_buffer.sv
  - source/epu_mac_pipe.sv
  - source/epu_axi_slave.sv
  - source/epu_top.sv
  - target: simulation
    files:
      - verification/epu_properties.sv
      - verification/epu_tb.sv

//--- verification/epu_tb.sv
`timescale 1ns/1ps

module epu_tb;

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DLY   = 1;
    // Six tests of 64 words in both directions at up to 25 cycles per word
    localparam int TIMEOUT_CYCLES = 20000;

    typedef struct packed {
        epu_axi_pkg::data_t data;
        epu_axi_pkg::id_t   id;
        logic               last;
    } rbeat_t;

    logic                  clk;
    logic                  rst;
    epu_axi_pkg::axi_req_t req;
    epu_axi_pkg::axi_rsp_t rsp;
    logic                  epuint;

    // Host view of the three buffers
    epu_axi_pkg::data_t in_mem  [epu_cfg_pkg::BUF_DEPTH];
    epu_axi_pkg::data_t wgt_mem [epu_cfg_pkg::BUF_DEPTH];
    epu_axi_pkg::data_t out_mem [epu_cfg_pkg::BUF_DEPTH];
    epu_axi_pkg::data_t wr_buf  [epu_cfg_pkg::BUF_DEPTH];
    epu_axi_pkg::addr_t buf_base [3];
    rbeat_t             exp_q [$];
    rbeat_t             exp_beat;
    logic [31:0]        rng_state;
    int                 cycles;
    int                 b_cycle;
    int                 ar_cycle;
    epu_axi_pkg::id_t   wr_id;
    epu_axi_pkg::id_t   rd_id;

    epu_top uut (
        .clk       (clk),
        .rst       (rst),
        .axi_req_i (req),
        .axi_rsp_o (rsp),
        .epuint_o  (epuint)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(epu_axi_pkg::data_t got, epu_axi_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: rdata 0x%08h, expected 0x%08h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_id(epu_axi_pkg::id_t got, epu_axi_pkg::id_t exp, string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s 0x%0h, expected 0x%0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_last(logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: rlast %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(logic [1:0] got, logic [1:0] exp, string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic expect_level(logic want, string what);
        if (epuint !== want) begin
            $display("Interrupt check failed at %0t: %s", $time, what);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic epu_axi_pkg::id_t random_id();
        logic [31:0] r;
        r = next_random();
        return r[epu_axi_pkg::ID_W-1:0];
    endfunction

    // Signed 16x16 product, negative results cleared under ReLU
    function automatic epu_axi_pkg::data_t expected_word(epu_cfg_pkg::epu_mode_e mode,
            epu_axi_pkg::data_t in_w, epu_axi_pkg::data_t wgt_w, epu_axi_pkg::data_t scalar);
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic signed [31:0] p;
        a = in_w[15:0];
        b = (mode == epu_cfg_pkg::MODE_SCALE) ? scalar[15:0] : wgt_w[15:0];
        p = a * b;
        if (mode == epu_cfg_pkg::MODE_VEC_RELU && p < 0)
            p = 0;
        return p;
    endfunction

    // Word address wraps inside the 256 byte region
    function automatic epu_axi_pkg::addr_t beat_addr(epu_axi_pkg::addr_t base, int beat);
        logic [5:0] word;
        word = base[7:2] + beat[5:0];
        return {base[31:8], word, 2'b00};
    endfunction

    function automatic epu_axi_pkg::data_t model_read(epu_axi_pkg::addr_t a);
        if (a[31:8] == epu_cfg_pkg::IN_BASE[31:8])
            return in_mem[a[7:2]];
        else if (a[31:8] == epu_cfg_pkg::OUT_BASE[31:8])
            return out_mem[a[7:2]];
        else if (a[31:8] == epu_cfg_pkg::WGT_BASE[31:8])
            return wgt_mem[a[7:2]];
        return '0;
    endfunction

    task automatic model_write(epu_axi_pkg::addr_t a, epu_axi_pkg::data_t d);
        if (a[31:8] == epu_cfg_pkg::IN_BASE[31:8])
            in_mem[a[7:2]] = d;
        else if (a[31:8] == epu_cfg_pkg::OUT_BASE[31:8])
            out_mem[a[7:2]] = d;
        else if (a[31:8] == epu_cfg_pkg::WGT_BASE[31:8])
            wgt_mem[a[7:2]] = d;
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic fill_random(int beats);
        for (int i = 0; i < beats; i++)
            wr_buf[i] = next_random();
    endtask

    task automatic write_burst(epu_axi_pkg::addr_t addr, epu_axi_pkg::id_t id,
            epu_axi_pkg::len_t len);
        logic             hs;
        epu_axi_pkg::id_t bid_seen;
        logic [1:0]       bresp_seen;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.awid    = id;
        req.awlen   = len;
        do begin
            @(negedge clk);
            hs = rsp.awready;
            step();
        end while (!hs);
        req.awvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            req.wvalid = 1'b1;
            req.wdata  = wr_buf[i];
            req.wlast  = (i == len);
            do begin
                @(negedge clk);
                hs = rsp.wready;
                step();
            end while (!hs);
            model_write(beat_addr(addr, i), wr_buf[i]);
        end
        req.wvalid = 1'b0;
        req.wlast  = 1'b0;
        req.bready = 1'b1;
        do begin
            @(negedge clk);
            hs         = rsp.bvalid;
            bid_seen   = rsp.bid;
            bresp_seen = rsp.bresp;
            if (hs)
                b_cycle = cycles;
            step();
        end while (!hs);
        req.bready = 1'b0;
        check_id(bid_seen, id, "bid");
        check_resp(bresp_seen, epu_axi_pkg::RESP_OKAY, "bresp");
    endtask

    task automatic read_burst(epu_axi_pkg::addr_t addr, epu_axi_pkg::id_t id,
            epu_axi_pkg::len_t len);
        logic   hs;
        int     n;
        rbeat_t beat;
        for (int i = 0; i <= len; i++) begin
            beat.data = model_read(beat_addr(addr, i));
            beat.id   = id;
            beat.last = (i == len);
            exp_q.push_back(beat);
        end
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.arid    = id;
        req.arlen   = len;
        do begin
            @(negedge clk);
            hs = rsp.arready;
            if (hs)
                ar_cycle = cycles;
            step();
        end while (!hs);
        req.arvalid = 1'b0;
        n = 0;
        while (n <= len) begin
            // rready low on about a quarter of the cycles
            req.rready = (next_random() % 4) != 0;
            @(negedge clk);
            if (rsp.rvalid && req.rready)
                n++;
            step();
        end
        req.rready = 1'b0;
    endtask

    // Scalar and control words in one two beat burst
    task automatic run_engine(epu_cfg_pkg::epu_mode_e mode, logic [7:0] count,
            epu_axi_pkg::data_t scalar);
        wr_buf[0] = scalar;
        wr_buf[1] = {16'h0, count, 5'b0, mode, 1'b1};
        write_burst(epu_cfg_pkg::CTRL_BASE, random_id(), 1);
        expect_level(1'b0, "interrupt still high after start");
        while (epuint !== 1'b1)
            step();
        repeat (8) begin
            expect_level(1'b1, "interrupt dropped before the next start");
            step();
        end
        for (int i = 0; i < count; i++)
            out_mem[i] = expected_word(mode, in_mem[i], wgt_mem[i], scalar);
        read_burst(epu_cfg_pkg::OUT_BASE, random_id(), 63);
    endtask

    // Every R beat against the scoreboard
    always @(negedge clk) begin
        if (!rst && rsp.rvalid && req.rready) begin
            if (exp_q.size() == 0) begin
                $display("A read beat arrived at %0t with nothing expected", $time);
                abort_run();
            end else begin
                exp_beat = exp_q.pop_front();
                check_data(rsp.rdata, exp_beat.data);
                check_id(rsp.rid, exp_beat.id, "rid");
                check_last(rsp.rlast, exp_beat.last);
                check_resp(rsp.rresp, epu_axi_pkg::RESP_OKAY, "rresp");
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycles);
            abort_run();
        end
    end

    initial begin
        req       = '0;
        rst       = 1'b1;
        cycles    = 0;
        b_cycle   = 0;
        ar_cycle  = 0;
        rng_state = 32'd78238;
        buf_base[0] = epu_cfg_pkg::IN_BASE;
        buf_base[1] = epu_cfg_pkg::OUT_BASE;
        buf_base[2] = epu_cfg_pkg::WGT_BASE;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        step();

        // Fill every buffer in 16 beat bursts, then read back
        for (int b = 0; b < 3; b++) begin
            for (int s = 0; s < 4; s++) begin
                fill_random(16);
                write_burst(buf_base[b] + s * 64, random_id(), 15);
            end
        end
        for (int b = 0; b < 3; b++)
            for (int s = 0; s < 4; s++)
                read_burst(buf_base[b] + s * 64, random_id(), 15);

        // Unmapped and control reads, dropped unmapped write
        read_burst(32'h4000_0000, random_id(), 3);
        read_burst(epu_cfg_pkg::CTRL_BASE, random_id(), 3);
        fill_random(16);
        write_burst(32'h9000_0000, random_id(), 15);
        for (int b = 0; b < 3; b++)
            read_burst(buf_base[b], random_id(), 63);

        run_engine(epu_cfg_pkg::MODE_SCALE, 8'd40, next_random());

        for (int s = 0; s < 4; s++) begin
            fill_random(16);
            write_burst(epu_cfg_pkg::IN_BASE + s * 64, random_id(), 15);
            fill_random(16);
            write_burst(epu_cfg_pkg::WGT_BASE + s * 64, random_id(), 15);
        end
        expect_level(1'b1, "interrupt dropped before the next start");
        run_engine(epu_cfg_pkg::MODE_VEC, 8'd64, next_random());
        expect_level(1'b1, "interrupt dropped before the next start");
        run_engine(epu_cfg_pkg::MODE_VEC_RELU, 8'd64, next_random());

        // Write and read requested together, write goes first
        fill_random(16);
        wr_id = random_id();
        rd_id = random_id();
        fork
            write_burst(epu_cfg_pkg::IN_BASE + 32'h40, wr_id, 15);
            read_burst(epu_cfg_pkg::WGT_BASE, rd_id, 15);
        join
        if (ar_cycle <= b_cycle) begin
            $display("The read address was accepted before the pending write completed");
            abort_run();
        end
        read_burst(epu_cfg_pkg::IN_BASE, random_id(), 63);

        repeat (4) step();
        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d expected read beats were never received", exp_q.size());
            abort_run();
        end
    end

endmodule

//--- verification/epu_properties.sv
`timescale 1ns/1ps

module epu_properties (
    input logic                  clk,
    input logic                  rst,
    input epu_axi_pkg::axi_req_t axi_req_i,
    input epu_axi_pkg::axi_rsp_t axi_rsp_i
);

    // Write response waits for the master
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi_rsp_i.bvalid && !axi_req_i.bready |=> axi_rsp_i.bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen under back-pressure
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi_rsp_i.rvalid && !axi_req_i.rready |=>
            axi_rsp_i.rvalid && $stable(axi_rsp_i.rdata))
        else $error("rvalid or rdata changed before rready");

    rlast_valid: assert property (@(posedge clk) disable iff (rst)
        axi_rsp_i.rlast |-> axi_rsp_i.rvalid)
        else $error("rlast high without rvalid");

    // One burst at a time
    one_dir: assert property (@(posedge clk) disable iff (rst)
        !(axi_rsp_i.wready && axi_rsp_i.rvalid))
        else $error("wready and rvalid high together");

endmodule

bind epu_axi_slave epu_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .axi_req_i (axi_req_i),
    .axi_rsp_i (axi_rsp_o)
);

//--- source/epu_top.sv
`timescale 1ns/1ps

module epu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  epu_axi_pkg::axi_req_t axi_req_i,
    output epu_axi_pkg::axi_rsp_t axi_rsp_o,
    output logic                  epuint_o
);

    // Host side ports
    epu_cfg_pkg::buf_port_t in_a, out_a, wgt_a;
    epu_axi_pkg::data_t     in_a_rdata, out_a_rdata, wgt_a_rdata;

    // Engine side ports
    epu_cfg_pkg::buf_port_t in_b, out_b, wgt_b;
    epu_axi_pkg::data_t     in_b_rdata, wgt_b_rdata;

    epu_cfg_pkg::epu_ctrl_t ctrl;
    logic                   start;

    epu_axi_slave u_slave (
        .clk         (clk),
        .rst         (rst),
        .axi_req_i   (axi_req_i),
        .axi_rsp_o   (axi_rsp_o),
        .in_port_o   (in_a),
        .out_port_o  (out_a),
        .wgt_port_o  (wgt_a),
        .in_rdata_i  (in_a_rdata),
        .out_rdata_i (out_a_rdata),
        .wgt_rdata_i (wgt_a_rdata),
        .start_o     (start),
        .ctrl_o      (ctrl)
    );

    epu_buffer u_in_buf (
        .clk       (clk),
        .a_i       (in_a),
        .a_rdata_o (in_a_rdata),
        .b_i       (in_b),
        .b_rdata_o (in_b_rdata)
    );

    // Engine only writes the output buffer
    epu_buffer u_out_buf (
        .clk       (clk),
        .a_i       (out_a),
        .a_rdata_o (out_a_rdata),
        .b_i       (out_b),
        .b_rdata_o ()
    );

    epu_buffer u_wgt_buf (
        .clk       (clk),
        .a_i       (wgt_a),
        .a_rdata_o (wgt_a_rdata),
        .b_i       (wgt_b),
        .b_rdata_o (wgt_b_rdata)
    );

    epu_mac_pipe u_mac (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .ctrl_i      (ctrl),
        .in_port_o   (in_b),
        .wgt_port_o  (wgt_b),
        .out_port_o  (out_b),
        .in_rdata_i  (in_b_rdata),
        .wgt_rdata_i (wgt_b_rdata),
        .finish_o    (epuint_o)
    );

endmodule

//--- source/epu_axi_slave.sv
`timescale 1ns/1ps

module epu_axi_slave (
    input  logic                   clk,
    input  logic                   rst,
    input  epu_axi_pkg::axi_req_t  axi_req_i,
    output epu_axi_pkg::axi_rsp_t  axi_rsp_o,
    output epu_cfg_pkg::buf_port_t in_port_o,
    output epu_cfg_pkg::buf_port_t out_port_o,
    output epu_cfg_pkg::buf_port_t wgt_port_o,
    input  epu_axi_pkg::data_t     in_rdata_i,
    input  epu_axi_pkg::data_t     out_rdata_i,
    input  epu_axi_pkg::data_t     wgt_rdata_i,
    output logic                   start_o,
    output epu_cfg_pkg::epu_ctrl_t ctrl_o
);

    epu_cfg_pkg::slave_state_e state_q, state_d;
    epu_cfg_pkg::buf_sel_e     sel;
    epu_cfg_pkg::buf_port_t    host_port;
    epu_cfg_pkg::buf_addr_t    word_q;
    epu_axi_pkg::addr_t        addr_q;
    epu_axi_pkg::id_t          id_q;
    epu_axi_pkg::len_t         len_q;
    epu_axi_pkg::len_t         beat_q;
    epu_axi_pkg::data_t        rdata;
    epu_axi_pkg::data_t        scalar_q;
    epu_cfg_pkg::epu_mode_e    mode_q;
    logic [7:0]                count_q;
    logic                      start_q;
    logic [epu_cfg_pkg::REGION_AW-1:0] reg_ofs;
    logic aw_hs, ar_hs, w_hs, r_hs, b_hs;
    logic last_beat, ctrl_wr;

    function automatic logic in_region(epu_axi_pkg::addr_t a, epu_axi_pkg::addr_t base);
        return a[epu_axi_pkg::ADDR_W-1:epu_cfg_pkg::REGION_AW] ==
               base[epu_axi_pkg::ADDR_W-1:epu_cfg_pkg::REGION_AW];
    endfunction

    // Write has priority over read in IDLE
    assign aw_hs = axi_req_i.awvalid && (state_q == epu_cfg_pkg::IDLE);
    assign ar_hs = axi_req_i.arvalid && !axi_req_i.awvalid && (state_q == epu_cfg_pkg::IDLE);
    assign w_hs  = axi_req_i.wvalid && (state_q == epu_cfg_pkg::W_DATA);
    assign r_hs  = axi_req_i.rready && (state_q == epu_cfg_pkg::R_DATA);
    assign b_hs  = axi_req_i.bready && (state_q == epu_cfg_pkg::B_RESP);

    assign last_beat = (beat_q == len_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            epu_cfg_pkg::IDLE: begin
                if (aw_hs)
                    state_d = epu_cfg_pkg::W_DATA;
                else if (ar_hs)
                    state_d = epu_cfg_pkg::R_ADDR;
            end
            epu_cfg_pkg::W_DATA: if (w_hs && axi_req_i.wlast) state_d = epu_cfg_pkg::B_RESP;
            epu_cfg_pkg::B_RESP: if (b_hs) state_d = epu_cfg_pkg::IDLE;
            epu_cfg_pkg::R_ADDR: state_d = epu_cfg_pkg::R_DATA;
            epu_cfg_pkg::R_DATA: begin
                if (r_hs)
                    state_d = last_beat ? epu_cfg_pkg::IDLE : epu_cfg_pkg::R_ADDR;
            end
            default: state_d = epu_cfg_pkg::IDLE;
        endcase
    end

    // Burst capture, word address and beat count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= epu_cfg_pkg::IDLE;
            addr_q  <= '0;
            id_q    <= '0;
            len_q   <= '0;
            beat_q  <= '0;
            word_q  <= '0;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                addr_q <= axi_req_i.awaddr;
                id_q   <= axi_req_i.awid;
                len_q  <= axi_req_i.awlen;
                beat_q <= '0;
                word_q <= axi_req_i.awaddr[epu_cfg_pkg::BUF_AW+1:2];
            end else if (ar_hs) begin
                addr_q <= axi_req_i.araddr;
                id_q   <= axi_req_i.arid;
                len_q  <= axi_req_i.arlen;
                beat_q <= '0;
                word_q <= axi_req_i.araddr[epu_cfg_pkg::BUF_AW+1:2];
            end else if (w_hs || r_hs) begin
                beat_q <= beat_q + 1'b1;
                word_q <= word_q + 1'b1;
            end
        end
    end

    // Region decode of the captured burst address
    always_comb begin
        if (in_region(addr_q, epu_cfg_pkg::IN_BASE))
            sel = epu_cfg_pkg::SEL_IN;
        else if (in_region(addr_q, epu_cfg_pkg::OUT_BASE))
            sel = epu_cfg_pkg::SEL_OUT;
        else if (in_region(addr_q, epu_cfg_pkg::WGT_BASE))
            sel = epu_cfg_pkg::SEL_WGT;
        else if (in_region(addr_q, epu_cfg_pkg::CTRL_BASE))
            sel = epu_cfg_pkg::SEL_CTRL;
        else
            sel = epu_cfg_pkg::SEL_NONE;
    end

    // Shared host port, enable steered to the selected buffer
    always_comb begin
        host_port.en    = w_hs || (state_q == epu_cfg_pkg::R_ADDR);
        host_port.we    = w_hs;
        host_port.addr  = word_q;
        host_port.wdata = axi_req_i.wdata;
        in_port_o       = host_port;
        out_port_o      = host_port;
        wgt_port_o      = host_port;
        in_port_o.en    = host_port.en && (sel == epu_cfg_pkg::SEL_IN);
        out_port_o.en   = host_port.en && (sel == epu_cfg_pkg::SEL_OUT);
        wgt_port_o.en   = host_port.en && (sel == epu_cfg_pkg::SEL_WGT);
    end

    // Buffer outputs are registered and hold while their port is idle
    always_comb begin
        case (sel)
            epu_cfg_pkg::SEL_IN:  rdata = in_rdata_i;
            epu_cfg_pkg::SEL_OUT: rdata = out_rdata_i;
            epu_cfg_pkg::SEL_WGT: rdata = wgt_rdata_i;
            default:              rdata = '0;
        endcase
    end

    // Control region writes
    assign reg_ofs = {word_q, 2'b00};
    assign ctrl_wr = w_hs && (sel == epu_cfg_pkg::SEL_CTRL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scalar_q <= '0;
            mode_q   <= epu_cfg_pkg::MODE_SCALE;
            count_q  <= '0;
            start_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (ctrl_wr && reg_ofs == epu_cfg_pkg::SCALAR_OFS)
                scalar_q <= axi_req_i.wdata;
            if (ctrl_wr && reg_ofs == epu_cfg_pkg::CTRL_OFS) begin
                mode_q  <= epu_cfg_pkg::epu_mode_e'(
                    axi_req_i.wdata[epu_cfg_pkg::CTRL_MODE_LSB +: 2]);
                count_q <= axi_req_i.wdata[epu_cfg_pkg::CTRL_COUNT_LSB +: 8];
                start_q <= axi_req_i.wdata[epu_cfg_pkg::CTRL_START_BIT];
            end
        end
    end

    assign start_o       = start_q;
    assign ctrl_o.mode   = mode_q;
    assign ctrl_o.count  = count_q;
    assign ctrl_o.scalar = scalar_q;

    always_comb begin
        axi_rsp_o.awready = (state_q == epu_cfg_pkg::IDLE);
        axi_rsp_o.arready = (state_q == epu_cfg_pkg::IDLE) && !axi_req_i.awvalid;
        axi_rsp_o.wready  = (state_q == epu_cfg_pkg::W_DATA);
        axi_rsp_o.bvalid  = (state_q == epu_cfg_pkg::B_RESP);
        axi_rsp_o.bid     = id_q;
        axi_rsp_o.bresp   = epu_axi_pkg::RESP_OKAY;
        axi_rsp_o.rvalid  = (state_q == epu_cfg_pkg::R_DATA);
        axi_rsp_o.rdata   = rdata;
        axi_rsp_o.rid     = id_q;
        axi_rsp_o.rresp   = epu_axi_pkg::RESP_OKAY;
        axi_rsp_o.rlast   = (state_q == epu_cfg_pkg::R_DATA) && last_beat;
    end

endmodule

//--- source/epu_mac_pipe.sv
`timescale 1ns/1ps

module epu_mac_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  epu_cfg_pkg::epu_ctrl_t ctrl_i,
    output epu_cfg_pkg::buf_port_t in_port_o,
    output epu_cfg_pkg::buf_port_t wgt_port_o,
    output epu_cfg_pkg::buf_port_t out_port_o,
    input  epu_axi_pkg::data_t     in_rdata_i,
    input  epu_axi_pkg::data_t     wgt_rdata_i,
    output logic                   finish_o
);

    epu_cfg_pkg::epu_mode_e mode_q;
    epu_axi_pkg::data_t     scalar_q;
    logic [7:0]             count_q;
    logic [7:0]             idx_q;
    logic                   busy_q, finish_q;
    logic                   issue, issue_last;
    logic                   s2_vld_q, s2_last_q;
    epu_cfg_pkg::buf_addr_t s2_idx_q;
    logic                   s3_vld_q, s3_last_q;
    epu_cfg_pkg::buf_addr_t s3_idx_q;
    logic signed [31:0]     s3_prod_q;
    logic signed [15:0]     op_a, op_b;
    logic signed [31:0]     prod;

    // Stage 1, one index per cycle until count is reached
    assign issue      = busy_q && (idx_q < count_q);
    assign issue_last = issue && (idx_q == count_q - 8'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            finish_q <= 1'b0;
            idx_q    <= '0;
            count_q  <= '0;
            mode_q   <= epu_cfg_pkg::MODE_SCALE;
            scalar_q <= '0;
        end else if (start_i && !busy_q) begin
            // Empty run finishes right away
            busy_q   <= (ctrl_i.count != 8'd0);
            finish_q <= (ctrl_i.count == 8'd0);
            idx_q    <= '0;
            count_q  <= ctrl_i.count;
            mode_q   <= ctrl_i.mode;
            scalar_q <= ctrl_i.scalar;
        end else begin
            if (issue)
                idx_q <= idx_q + 8'd1;
            if (s3_vld_q && s3_last_q) begin
                busy_q   <= 1'b0;
                finish_q <= 1'b1;
            end
        end
    end

    always_comb begin
        in_port_o.en     = issue;
        in_port_o.we     = 1'b0;
        in_port_o.addr   = idx_q[epu_cfg_pkg::BUF_AW-1:0];
        in_port_o.wdata  = '0;
        // Weights are not needed when scaling
        wgt_port_o.en    = issue && (mode_q != epu_cfg_pkg::MODE_SCALE);
        wgt_port_o.we    = 1'b0;
        wgt_port_o.addr  = idx_q[epu_cfg_pkg::BUF_AW-1:0];
        wgt_port_o.wdata = '0;
    end

    // Stage 2 multiply on returning words
    assign op_a = in_rdata_i[15:0];
    assign op_b = (mode_q == epu_cfg_pkg::MODE_SCALE) ? scalar_q[15:0] : wgt_rdata_i[15:0];
    assign prod = op_a * op_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_vld_q <= 1'b0;
            s3_vld_q <= 1'b0;
        end else begin
            s2_vld_q <= issue;
            s3_vld_q <= s2_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        s2_idx_q  <= idx_q[epu_cfg_pkg::BUF_AW-1:0];
        s2_last_q <= issue_last;
        s3_idx_q  <= s2_idx_q;
        s3_last_q <= s2_last_q;
        s3_prod_q <= prod;
    end

    // Stage 3 optional ReLU and write back
    always_comb begin
        out_port_o.en    = s3_vld_q;
        out_port_o.we    = 1'b1;
        out_port_o.addr  = s3_idx_q;
        if (mode_q == epu_cfg_pkg::MODE_VEC_RELU && s3_prod_q[31])
            out_port_o.wdata = '0;
        else
            out_port_o.wdata = s3_prod_q;
    end

    assign finish_o = finish_q;

endmodule

//--- source/epu_buffer.sv
`timescale 1ns/1ps

module epu_buffer (
    input  logic                   clk,
    input  epu_cfg_pkg::buf_port_t a_i,
    output epu_axi_pkg::data_t     a_rdata_o,
    input  epu_cfg_pkg::buf_port_t b_i,
    output epu_axi_pkg::data_t     b_rdata_o
);

    epu_axi_pkg::data_t mem [epu_cfg_pkg::BUF_DEPTH];

    // Both ports may write, port B lands last on a collision
    always_ff @(posedge clk) begin
        if (a_i.en && a_i.we)
            mem[a_i.addr] <= a_i.wdata;
        if (b_i.en && b_i.we)
            mem[b_i.addr] <= b_i.wdata;
    end

    // Read data updates only on a read, otherwise holds
    always_ff @(posedge clk) begin
        if (a_i.en && !a_i.we)
            a_rdata_o <= mem[a_i.addr];
    end

    always_ff @(posedge clk) begin
        if (b_i.en && !b_i.we)
            b_rdata_o <= mem[b_i.addr];
    end

endmodule

//--- source/epu_cfg_pkg.sv
package epu_cfg_pkg;

    // Buffer geometry
    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW    = 6;

    typedef logic [BUF_AW-1:0] buf_addr_t;

    // Address map, each region is 2**REGION_AW bytes
    localparam epu_axi_pkg::addr_t IN_BASE   = 32'h5000_0000;
    localparam epu_axi_pkg::addr_t OUT_BASE  = 32'h6000_0000;
    localparam epu_axi_pkg::addr_t WGT_BASE  = 32'h7000_0000;
    localparam epu_axi_pkg::addr_t CTRL_BASE = 32'h8000_0000;
    localparam int REGION_AW = 8;

    // Control region registers
    localparam logic [REGION_AW-1:0] SCALAR_OFS = 8'h00;
    localparam logic [REGION_AW-1:0] CTRL_OFS   = 8'h04;

    // Control register fields
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_MODE_LSB  = 1;
    localparam int CTRL_COUNT_LSB = 8;

    typedef enum logic [2:0] {
        IDLE,
        R_ADDR,
        R_DATA,
        W_DATA,
        B_RESP
    } slave_state_e;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_IN,
        SEL_OUT,
        SEL_WGT,
        SEL_CTRL
    } buf_sel_e;

    typedef enum logic [1:0] {
        MODE_SCALE,
        MODE_VEC,
        MODE_VEC_RELU
    } epu_mode_e;

    typedef struct packed {
        logic               en;
        logic               we;
        buf_addr_t          addr;
        epu_axi_pkg::data_t wdata;
    } buf_port_t;

    typedef struct packed {
        epu_mode_e          mode;
        logic [7:0]         count;
        epu_axi_pkg::data_t scalar;
    } epu_ctrl_t;

endpackage

//--- source/epu_axi_pkg.sv
package epu_axi_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;

    // Only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Master to slave
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        id_t   awid;
        len_t  awlen;
        logic  wvalid;
        data_t wdata;
        logic  wlast;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        id_t   arid;
        len_t  arlen;
        logic  rready;
    } axi_req_t;

    // Slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        id_t        bid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        data_t      rdata;
        id_t        rid;
        logic [1:0] rresp;
        logic       rlast;
    } axi_rsp_t;

endpackage
